//--- Bender.yml
package:
  name: lcd_spi

sources:
  - files:
      - common/lcd_pkg.sv
      - common/axil_pkg.sv
  - files:
      - lcd_spi/lcd_item_fifo.sv
      - lcd_spi/lcd_spi_serializer.sv
      - design/lcd_regs.sv
      - design/lcd_spi_top.sv
  - target: simulation
    files:
      - sim/lcd_spi_monitor.sv
      - sim/tb_lcd_spi.sv

//--- common/axil_pkg.sv
package axil_pkg;

	localparam int axil_addr_w = 4;  // only the register offset is decoded
	localparam int axil_data_w = 32;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axil_resp_e;

	typedef struct packed {
		logic                   awvalid;
		logic [axil_addr_w-1:0] awaddr;
		logic                   wvalid;
		logic [axil_data_w-1:0] wdata;
		logic [3:0]             wstrb;
		logic                   bready;
		logic                   arvalid;
		logic [axil_addr_w-1:0] araddr;
		logic                   rready;
	} axil_req_t;

	typedef struct packed {
		logic                   awready;
		logic                   wready;
		logic                   bvalid;
		axil_resp_e             bresp;
		logic                   arready;
		logic                   rvalid;
		logic [axil_data_w-1:0] rdata;
		axil_resp_e             rresp;
	} axil_rsp_t;

endpackage

//--- common/lcd_pkg.sv
package lcd_pkg;

	localparam int lcd_fifo_depth = 8;  // default number of queued display items
	localparam int lcd_lvl_w      = 4;  // level field must be able to hold the full depth
	localparam int lcd_div_w      = 8;  // width of the serial clock divider
	localparam int lcd_cmd_bits   = 8;  // bits shifted out for a command
	localparam int lcd_data_bits  = 16; // bits shifted out for a pixel

	// register offsets on the host bus
	localparam logic [3:0] reg_ctrl   = 4'h0;
	localparam logic [3:0] reg_status = 4'h4;
	localparam logic [3:0] reg_cmd    = 4'h8;
	localparam logic [3:0] reg_pixel  = 4'hc;

	// field positions inside the CTRL word
	localparam int ctrl_en_bit  = 0;
	localparam int ctrl_div_lsb = 8;

	typedef enum logic {
		LCD_CMD  = 1'b0, // sent with dc low
		LCD_DATA = 1'b1  // sent with dc high
	} lcd_kind_e;

	typedef struct packed {
		lcd_kind_e   kind;
		logic [15:0] value; // a command only uses the low byte
	} lcd_item_t;

	typedef struct packed {
		logic                 en;
		logic [lcd_div_w-1:0] div; // each sck half period is div+1 clocks
	} lcd_ctrl_t;

	typedef struct packed {
		logic cs;
		logic dc;
		logic sck;
		logic mosi;
	} lcd_pins_t;

endpackage

//--- design/lcd_regs.sv
`timescale 1ns/10ps

module lcd_regs import axil_pkg::*, lcd_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 lcd_cs,
	input  axil_req_t            req,
	output axil_rsp_t            rsp,
	output logic                 push,
	output lcd_item_t            push_item,
	input  logic                 full,
	input  logic [lcd_lvl_w-1:0] level,
	input  logic                 busy,
	output lcd_ctrl_t            ctrl
);

	logic                   live;      // goes high one cycle after reset is released
	logic                   bvalid;
	logic                   rvalid;
	axil_resp_e             bresp;
	axil_resp_e             rresp;
	logic [axil_data_w-1:0] rdata;
	logic                   wr_queue;  // write targets CMD or PIXEL
	logic                   wr_mapped; // write targets a writable register
	logic                   wr_ready;
	logic                   wr_go;
	logic                   rd_ready;
	logic                   rd_go;
	logic [axil_data_w-1:0] ctrl_word;
	logic [axil_data_w-1:0] status_word;

	assign wr_queue  = (req.awaddr == reg_cmd) || (req.awaddr == reg_pixel);
	assign wr_mapped = wr_queue || (req.awaddr == reg_ctrl);
	assign wr_ready  = live && !bvalid && !(wr_queue && full); // stall queue writes while full
	assign wr_go     = req.awvalid && req.wvalid && wr_ready;
	assign rd_ready  = live && !rvalid;
	assign rd_go     = req.arvalid && rd_ready;

	assign ctrl_word   = (axil_data_w'(ctrl.div) << ctrl_div_lsb) | axil_data_w'(ctrl.en);
	assign status_word = {{(axil_data_w - lcd_lvl_w - 2){1'b0}}, full, busy, level};

	assign push = wr_go && wr_queue; // the level follows one cycle later

	always_comb begin
		if (req.awaddr == reg_pixel) begin
			push_item.kind  = LCD_DATA;
			push_item.value = req.wdata[15:0];
		end else begin
			push_item.kind  = LCD_CMD;
			push_item.value = {8'h00, req.wdata[7:0]}; // upper byte of a command stays zero
		end
	end

	always_ff @(posedge clk_sys or posedge lcd_cs) begin
		if (lcd_cs) begin
			live   <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			ctrl   <= '0;
		end else begin
			live <= 1'b1;
			if (wr_go)
				bvalid <= 1'b1;
			else if (req.bready)
				bvalid <= 1'b0; // response holds until the host takes it
			if (rd_go)
				rvalid <= 1'b1;
			else if (req.rready)
				rvalid <= 1'b0;
			if (wr_go && (req.awaddr == reg_ctrl)) begin
				ctrl.en  <= req.wdata[ctrl_en_bit];
				ctrl.div <= req.wdata[ctrl_div_lsb +: lcd_div_w];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_go)
			bresp <= wr_mapped ? OKAY : SLVERR; // STATUS and holes reject writes
		if (rd_go) begin
			rresp <= OKAY;
			case (req.araddr)
				reg_ctrl:   rdata <= ctrl_word;
				reg_status: rdata <= status_word;
				reg_cmd,
				reg_pixel:  rdata <= '0; // write only, reads back as zero
				default: begin
					rdata <= '0;
					rresp <= SLVERR;
				end
			endcase
		end
	end

	always_comb begin
		rsp.awready = wr_ready;
		rsp.wready  = wr_ready; // address and data are always taken together
		rsp.bvalid  = bvalid;
		rsp.bresp   = bresp;
		rsp.arready = rd_ready;
		rsp.rvalid  = rvalid;
		rsp.rdata   = rdata;
		rsp.rresp   = rresp;
	end

endmodule

//--- design/lcd_spi_top.sv
`timescale 1ns/10ps

module lcd_spi_top import axil_pkg::*, lcd_pkg::*; (
	input  logic      clk_sys,
	input  logic      lcd_cs,
	input  axil_req_t req,
	output axil_rsp_t rsp,
	output logic      disp_cs,
	output logic      disp_dc,
	output logic      disp_sck,
	output logic      disp_mosi
);

	logic                 push;
	lcd_item_t            push_item;
	logic                 pop;
	lcd_item_t            pop_item;
	logic                 empty;
	logic                 full;
	logic [lcd_lvl_w-1:0] level;
	logic                 busy;
	lcd_ctrl_t            ctrl;
	lcd_pins_t            pins;

	lcd_regs regs0 (
		.clk_sys   (clk_sys),
		.lcd_cs    (lcd_cs),
		.req       (req),
		.rsp       (rsp),
		.push      (push),
		.push_item (push_item),
		.full      (full),
		.level     (level),
		.busy      (busy),
		.ctrl      (ctrl)
	);

	lcd_item_fifo #(
		.depth (lcd_fifo_depth)
	) fifo0 (
		.clk_sys   (clk_sys),
		.lcd_cs    (lcd_cs),
		.push      (push),
		.push_item (push_item),
		.pop       (pop),
		.pop_item  (pop_item),
		.empty     (empty),
		.full      (full),
		.level     (level)
	);

	lcd_spi_serializer ser0 (
		.clk_sys  (clk_sys),
		.lcd_cs   (lcd_cs),
		.ctrl     (ctrl),
		.empty    (empty),
		.pop_item (pop_item),
		.pop      (pop),
		.busy     (busy),
		.pins     (pins)
	);

	assign disp_cs   = pins.cs;
	assign disp_dc   = pins.dc;
	assign disp_sck  = pins.sck;
	assign disp_mosi = pins.mosi;

endmodule

//--- lcd_spi/lcd_item_fifo.sv
`timescale 1ns/10ps

module lcd_item_fifo import lcd_pkg::*; #(
	parameter int depth = lcd_fifo_depth
) (
	input  logic                 clk_sys,
	input  logic                 lcd_cs,
	input  logic                 push,
	input  lcd_item_t            push_item,
	input  logic                 pop,
	output lcd_item_t            pop_item,
	output logic                 empty,
	output logic                 full,
	output logic [lcd_lvl_w-1:0] level
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

	lcd_item_t        mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	// pointers wrap explicitly so any depth works, not only powers of two
	function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_push  = push && !full; // a push into a full queue is dropped
	assign do_pop   = pop && !empty;
	assign empty    = (level == '0);
	assign full     = (level == lcd_lvl_w'(depth));
	assign pop_item = mem[rd_ptr]; // head is visible without a read cycle

	always_ff @(posedge clk_sys) begin
		if (do_push)
			mem[wr_ptr] <= push_item;
	end

	always_ff @(posedge clk_sys or posedge lcd_cs) begin
		if (lcd_cs) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_next(rd_ptr);
			if (do_push && !do_pop)
				level <= level + 1'b1;
			else if (do_pop && !do_push)
				level <= level - 1'b1; // simultaneous push and pop leave the level alone
		end
	end

endmodule

//--- lcd_spi/lcd_spi_serializer.sv
`timescale 1ns/10ps

module lcd_spi_serializer import lcd_pkg::*; (
	input  logic      clk_sys,
	input  logic      lcd_cs,
	input  lcd_ctrl_t ctrl,
	input  logic      empty,
	input  lcd_item_t pop_item,
	output logic      pop,
	output logic      busy,
	output lcd_pins_t pins
);

	typedef enum logic [2:0] {
		IDLE,
		LOAD,     // chip select low, first bit on mosi
		SHIFT_LO,
		SHIFT_HI,
		END       // high phase of the last bit
	} state_e;

	state_e               state;
	logic [lcd_div_w-1:0] div_cnt;
	logic [3:0]           bit_cnt;   // bits still to send after the current one
	logic [15:0]          shift;     // current bit sits in bit 15
	logic                 half_done;
	logic [15:0]          load_word;
	logic [3:0]           load_bits;

	assign half_done = (div_cnt >= ctrl.div); // also recovers if div shrinks mid-item
	assign pop       = ctrl.en && !empty && ((state == IDLE) || ((state == END) && half_done));
	assign busy      = pop || (state != IDLE);

	always_comb begin
		if (pop_item.kind == LCD_DATA) begin
			load_word = pop_item.value;
			load_bits = 4'(lcd_data_bits - 1);
		end else begin
			load_word = {pop_item.value[7:0], 8'h00}; // left align so the MSB leaves first
			load_bits = 4'(lcd_cmd_bits - 1);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (pop)
			shift <= load_word;
		else if ((state == SHIFT_HI) && half_done)
			shift <= {shift[14:0], 1'b0};
	end

	always_ff @(posedge clk_sys or posedge lcd_cs) begin
		if (lcd_cs) begin
			state     <= IDLE;
			div_cnt   <= '0;
			bit_cnt   <= '0;
			pins.cs   <= 1'b1;
			pins.dc   <= 1'b0;
			pins.sck  <= 1'b0;
			pins.mosi <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					div_cnt <= '0;
					if (pop) begin
						bit_cnt   <= load_bits;
						pins.cs   <= 1'b0;
						pins.dc   <= (pop_item.kind == LCD_DATA);
						pins.mosi <= load_word[15];
						state     <= LOAD;
					end
				end
				LOAD: state <= SHIFT_LO;
				SHIFT_LO: begin
					if (half_done) begin
						div_cnt  <= '0;
						pins.sck <= 1'b1; // display samples mosi on this edge
						state    <= (bit_cnt == '0) ? END : SHIFT_HI;
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				SHIFT_HI: begin
					if (half_done) begin
						div_cnt   <= '0;
						pins.sck  <= 1'b0;
						pins.mosi <= shift[14]; // next bit goes out with the falling edge
						bit_cnt   <= bit_cnt - 1'b1;
						state     <= SHIFT_LO;
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				END: begin
					if (half_done) begin
						div_cnt  <= '0;
						pins.sck <= 1'b0;
						if (pop) begin
							// back to back item, chip select stays low
							bit_cnt   <= load_bits;
							pins.dc   <= (pop_item.kind == LCD_DATA);
							pins.mosi <= load_word[15];
							state     <= SHIFT_LO;
						end else begin
							pins.cs   <= 1'b1;
							pins.mosi <= 1'b0;
							state     <= IDLE;
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- sim.f
common/lcd_pkg.sv
common/axil_pkg.sv
lcd_spi/lcd_item_fifo.sv
lcd_spi/lcd_spi_serializer.sv
design/lcd_regs.sv
design/lcd_spi_top.sv
sim/lcd_spi_monitor.sv
sim/tb_lcd_spi.sv

//--- sim/lcd_spi_monitor.sv
`timescale 1ns/10ps

module lcd_spi_monitor import lcd_pkg::*; (
	input logic disp_cs,
	input logic disp_dc,
	input logic disp_sck,
	input logic disp_mosi
);

	lcd_item_t   items [$];  // rebuilt items, oldest first
	int          sck_edges;  // every rising edge of sck, selected or not
	int          cs_rises;
	int          nbits;
	logic [15:0] sr = '0;
	lcd_item_t   item;

	// the display samples mosi on the rising edge of sck
	always @(posedge disp_sck) begin
		sck_edges++;
		if (disp_cs === 1'b0) begin
			sr = {sr[14:0], disp_mosi};
			nbits++;
			if (!disp_dc && nbits == lcd_cmd_bits) begin
				item.kind  = LCD_CMD;
				item.value = {8'h00, sr[7:0]};
				items.push_back(item);
				nbits = 0;
			end else if (disp_dc && nbits == lcd_data_bits) begin
				item.kind  = LCD_DATA;
				item.value = sr;
				items.push_back(item);
				nbits = 0;
			end
		end
	end

	always @(posedge disp_cs) begin
		cs_rises++;
		nbits = 0; // a frame that was cut short leaves nothing behind
	end

endmodule

//--- sim/tb_lcd_spi.sv
`timescale 1ns/10ps

module tb_lcd_spi import axil_pkg::*, lcd_pkg::*; ();

	typedef enum logic [2:0] {
		OP_WR,
		OP_RD,
		OP_WR_BLOCK, // write that must stall while the queue is full
		OP_DRAIN,    // wait until every expected item has left on the pins
		OP_MARK,     // remember the edge counters of the monitor
		OP_EDGES     // compare edge counts since the mark with cs in 31:16 and sck in 15:0
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [3:0]  addr;
		logic [31:0] data;
		logic [1:0]  rnd;   // 1 draws a new pixel value, 2 reuses the last one
		axil_resp_e  resp;
		logic [31:0] rdata;
	} step_t;

	localparam int n_steps        = 43;
	localparam int max_div        = 3;
	localparam int timeout_cycles = n_steps * 16 * 2 * (max_div + 1) + 2000;

	step_t steps [n_steps] = '{
		'{OP_RD, reg_ctrl, 32'h0, 2'd0, OKAY, 32'h0},
		'{OP_WR, reg_ctrl, 32'h101, 2'd0, OKAY, 32'h0},
		'{OP_RD, reg_ctrl, 32'h0, 2'd0, OKAY, 32'h101},
		'{OP_WR, reg_cmd, 32'h2c, 2'd0, OKAY, 32'h0},
		'{OP_WR, reg_pixel, 32'h0, 2'd1, OKAY, 32'h0},
		'{OP_WR, reg_pixel, 32'h0, 2'd1, OKAY, 32'h0},
		'{OP_WR, reg_cmd, 32'hffff_ff3a, 2'd0, OKAY, 32'h0},
		'{OP_WR, reg_pixel, 32'h0, 2'd1, OKAY, 32'h0},
		'{OP_WR, reg_cmd, 32'h29, 2'd0, OKAY, 32'h0},
		'{OP_DRAIN, 4'h0, 32'h0, 2'd0, OKAY, 32'h0},
		'{OP_WR, reg_ctrl, 32'h100, 2'd0, OKAY, 32'h0},
		'{OP_MARK, 4'h0, 32'h0, 2'd0, OKAY, 32'h0},
		'{OP_WR, reg_pixel, 32'h0, 2'd1, OKAY, 32'h0},
		'{OP_WR, reg_pixel, 32'h0, 2'd1, OKAY, 32'h0},
		'{OP_WR, reg_pixel, 32'h0, 2'd1, OKAY, 32'h0},
		'{OP_WR, reg_pixel, 32'h0, 2'd1, OKAY, 32'h0},
		'{OP_WR, reg_pixel, 32'h0, 2'd1, OKAY, 32'h0},
		'{OP_WR, reg_pixel, 32'h0, 2'd1, OKAY, 32'h0},
		'{OP_WR, reg_pixel, 32'h0, 2'd1, OKAY, 32'h0},
		'{OP_WR, reg_pixel, 32'h0, 2'd1, OKAY, 32'h0},
		'{OP_WR_BLOCK, reg_pixel, 32'h0, 2'd1, OKAY, 32'h0},
		'{OP_RD, reg_status, 32'h0, 2'd0, OKAY, 32'h28},
		'{OP_EDGES, 4'h0, 32'h0, 2'd0, OKAY, 32'h0},
		'{OP_WR, reg_ctrl, 32'h101, 2'd0, OKAY, 32'h0},
		'{OP_WR, reg_pixel, 32'h0, 2'd2, OKAY, 32'h0},
		'{OP_DRAIN, 4'h0, 32'h0, 2'd0, OKAY, 32'h0},
		'{OP_WR, reg_status, 32'h1, 2'd0, SLVERR, 32'h0},
		'{OP_WR, 4'h2, 32'h5, 2'd0, SLVERR, 32'h0},
		'{OP_RD, 4'h6, 32'h0, 2'd0, SLVERR, 32'h0},
		'{OP_RD, 4'h1, 32'h0, 2'd0, SLVERR, 32'h0},
		'{OP_RD, reg_pixel, 32'h0, 2'd0, OKAY, 32'h0},
		'{OP_RD, reg_cmd, 32'h0, 2'd0, OKAY, 32'h0},
		'{OP_DRAIN, 4'h0, 32'h0, 2'd0, OKAY, 32'h0},
		'{OP_WR, reg_ctrl, 32'h301, 2'd0, OKAY, 32'h0},
		'{OP_RD, reg_ctrl, 32'h0, 2'd0, OKAY, 32'h301},
		'{OP_MARK, 4'h0, 32'h0, 2'd0, OKAY, 32'h0},
		'{OP_WR, reg_cmd, 32'h2c, 2'd0, OKAY, 32'h0},
		'{OP_WR, reg_pixel, 32'h0, 2'd1, OKAY, 32'h0},
		'{OP_WR, reg_pixel, 32'h0, 2'd1, OKAY, 32'h0},
		'{OP_WR, reg_pixel, 32'h0, 2'd1, OKAY, 32'h0},
		'{OP_DRAIN, 4'h0, 32'h0, 2'd0, OKAY, 32'h0},
		'{OP_EDGES, 4'h0, 32'h0001_0038, 2'd0, OKAY, 32'h0},
		'{OP_RD, reg_status, 32'h0, 2'd0, OKAY, 32'h0}
	};

	logic      clk_sys;
	logic      lcd_cs;
	axil_req_t req;
	axil_rsp_t rsp;
	logic      disp_cs;
	logic      disp_dc;
	logic      disp_sck;
	logic      disp_mosi;

	lcd_item_t exp_q [$];       // items in the order they were written
	int        cycles;
	int        exp_half = 1;    // sck half period in clk_sys cycles, divider + 1
	int        half_cnt;
	logic      have_edge;
	logic      last_sck;

	lcd_spi_top dut0 (
		.clk_sys   (clk_sys),
		.lcd_cs    (lcd_cs),
		.req       (req),
		.rsp       (rsp),
		.disp_cs   (disp_cs),
		.disp_dc   (disp_dc),
		.disp_sck  (disp_sck),
		.disp_mosi (disp_mosi)
	);

	lcd_spi_monitor mon0 (
		.disp_cs   (disp_cs),
		.disp_dc   (disp_dc),
		.disp_sck  (disp_sck),
		.disp_mosi (disp_mosi)
	);

	always #4 clk_sys = ~clk_sys;

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_item(input lcd_item_t got, input lcd_item_t exp);
		if (got !== exp)
			fail_stop($sformatf("FAILED %0t disp_item got %05h exp %05h", $time, got, exp));
	endtask

	task automatic check_rdata(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_stop($sformatf("FAILED %0t %s got %08h exp %08h", $time, name, got, exp));
	endtask

	task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
		if (got !== exp)
			fail_stop($sformatf("FAILED %0t %s got %s exp %s", $time, name, got.name(), exp.name()));
	endtask

	task automatic check_pin(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_stop($sformatf("FAILED %0t %s got %b exp %b", $time, name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			fail_stop($sformatf("FAILED %0t %s got %0d exp %0d", $time, name, got, exp));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// a command keeps only its low byte, a pixel its low half word
	function automatic lcd_item_t item_for_write(input logic [3:0] addr, input logic [31:0] data);
		lcd_item_t it;
		if (addr == reg_pixel) begin
			it.kind  = LCD_DATA;
			it.value = data[15:0];
		end else begin
			it.kind  = LCD_CMD;
			it.value = {8'h00, data[7:0]};
		end
		return it;
	endfunction

	task automatic bus_write(input logic [3:0] addr, input logic [31:0] data,
			output axil_resp_e resp);
		@(posedge clk_sys);
		req.awvalid <= 1'b1;
		req.awaddr  <= addr;
		req.wvalid  <= 1'b1;
		req.wdata   <= data;
		req.wstrb   <= 4'hf;
		req.bready  <= 1'b1;
		do @(negedge clk_sys); while (!rsp.awready || !rsp.wready); // accepted at the next edge
		@(posedge clk_sys);
		req.awvalid <= 1'b0;
		req.wvalid  <= 1'b0;
		do @(negedge clk_sys); while (!rsp.bvalid);
		resp = rsp.bresp;
		@(posedge clk_sys);
		req.bready <= 1'b0;
	endtask

	task automatic bus_read(input logic [3:0] addr, output logic [31:0] data,
			output axil_resp_e resp);
		@(posedge clk_sys);
		req.arvalid <= 1'b1;
		req.araddr  <= addr;
		req.rready  <= 1'b1;
		do @(negedge clk_sys); while (!rsp.arready);
		@(posedge clk_sys);
		req.arvalid <= 1'b0;
		do @(negedge clk_sys); while (!rsp.rvalid);
		data = rsp.rdata;
		resp = rsp.rresp;
		@(posedge clk_sys);
		req.rready <= 1'b0;
	endtask

	task automatic write_blocked(input logic [3:0] addr, input logic [31:0] data);
		@(posedge clk_sys);
		req.awvalid <= 1'b1;
		req.awaddr  <= addr;
		req.wvalid  <= 1'b1;
		req.wdata   <= data;
		req.wstrb   <= 4'hf;
		repeat (16) begin
			@(negedge clk_sys);
			if (rsp.awready || rsp.wready)
				fail_stop("a queue write was accepted while the queue was full");
		end
		@(posedge clk_sys);
		req.awvalid <= 1'b0; // the host gives up and writes the value again later
		req.wvalid  <= 1'b0;
	endtask

	task automatic drain_and_compare();
		lcd_item_t got;
		do begin
			@(negedge clk_sys);
			while (mon0.items.size() > 0) begin
				got = mon0.items.pop_front();
				if (exp_q.size() == 0)
					fail_stop("an item appeared on the display pins that was never written");
				else
					check_item(got, exp_q.pop_front());
			end
		end while (exp_q.size() != 0 || !disp_cs);
	endtask

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > timeout_cycles)
			fail_stop("the run took too many cycles and was stopped");
	end

	// every sck phase between two edges inside one selection must last divider+1 cycles
	always @(negedge clk_sys) begin
		if (lcd_cs) begin
			have_edge = 1'b0;
			half_cnt  = 0;
			last_sck  = 1'b0;
		end else begin
			if (disp_sck != last_sck) begin
				if (have_edge)
					check_count("disp_sck half period", half_cnt, exp_half);
				have_edge = 1'b1;
				half_cnt  = 1;
			end else begin
				half_cnt++;
			end
			last_sck = disp_sck;
			if (disp_cs)
				have_edge = 1'b0;
		end
	end

	initial begin
		step_t       s;
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic [31:0] rng;
		axil_resp_e  resp;
		int          sck_mark;
		int          cs_mark;
		clk_sys  = 1'b0;
		lcd_cs   = 1'b1;
		req      = '0;
		rng      = 32'h677e6cd4;
		sck_mark = 0;
		cs_mark  = 0;
		repeat (10) @(posedge clk_sys);
		lcd_cs <= 1'b0;
		@(negedge clk_sys);
		check_pin("disp_cs", disp_cs, 1'b1);
		check_pin("disp_sck", disp_sck, 1'b0);
		check_pin("disp_mosi", disp_mosi, 1'b0);
		check_pin("disp_dc", disp_dc, 1'b0);
		check_pin("awready", rsp.awready, 1'b0); // one quiet cycle after reset
		check_pin("wready", rsp.wready, 1'b0);
		@(negedge clk_sys);
		check_pin("awready", rsp.awready, 1'b1);
		check_pin("wready", rsp.wready, 1'b1);
		check_pin("arready", rsp.arready, 1'b1);
		for (int i = 0; i < n_steps; i++) begin
			s     = steps[i];
			wdata = s.data;
			if (s.rnd == 2'd1) begin
				rng   = xorshift32(rng);
				wdata = rng;
			end else if (s.rnd == 2'd2) begin
				wdata = rng;
			end
			case (s.op)
				OP_WR: begin
					bus_write(s.addr, wdata, resp);
					check_resp("bresp", resp, s.resp);
					if (s.addr == reg_cmd || s.addr == reg_pixel)
						exp_q.push_back(item_for_write(s.addr, wdata));
					if (s.addr == reg_ctrl)
						exp_half = int'(wdata[15:8]) + 1;
				end
				OP_RD: begin
					bus_read(s.addr, rdata, resp);
					check_resp("rresp", resp, s.resp);
					if (s.resp == OKAY)
						check_rdata("rdata", rdata, s.rdata);
				end
				OP_WR_BLOCK: write_blocked(s.addr, wdata);
				OP_DRAIN: drain_and_compare();
				OP_MARK: begin
					sck_mark = mon0.sck_edges;
					cs_mark  = mon0.cs_rises;
				end
				default: begin
					check_count("sck rising edges", mon0.sck_edges - sck_mark, int'(s.data[15:0]));
					check_count("disp_cs rising edges", mon0.cs_rises - cs_mark,
						int'(s.data[31:16]));
				end
			endcase
		end
		if (exp_q.size() != 0 || mon0.items.size() != 0) begin
			fail_stop("items were left over at the end of the run");
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule
